// ==== dbus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbus_decode (
    input  wire dbus_pkg::dbus_cmd_t  dbus_cmd_i,
    input  wire logic                 cmd_valid_i,
    output periph_pkg::sdram_req_t    sdram_req_o,
    output logic                      sdram_valid_o,
    output logic                      uart_valid_o,
    output logic                      uart_rx_o,
    output logic [7:0]                uart_byte_o,
    output dbus_pkg::port_e           port_o
);

    logic [dbus_pkg::region_w-1:0] region;

    assign region = dbus_cmd_i.addr[dbus_pkg::region_lsb +: dbus_pkg::region_w];

    // ----------------------------------------------------------------------
    // region classification
    // ----------------------------------------------------------------------
    always_comb begin
        case (region)
            dbus_pkg::region_sdram: port_o = dbus_pkg::port_sdram;
            dbus_pkg::region_uart:  port_o = dbus_pkg::port_uart;
            default:                port_o = dbus_pkg::port_null;   // acked by result stage
        endcase
    end

    // ----------------------------------------------------------------------
    // per-target requests
    // ----------------------------------------------------------------------
    always_comb begin
        sdram_req_o.addr  = dbus_cmd_i.addr[2 +: periph_pkg::sdram_aw];  // drop byte offset
        sdram_req_o.we    = dbus_cmd_i.we;
        sdram_req_o.wdata = dbus_cmd_i.wdata;
        sdram_req_o.strb  = dbus_cmd_i.strb;
    end

    assign sdram_valid_o = cmd_valid_i && (port_o == dbus_pkg::port_sdram);
    assign uart_valid_o  = cmd_valid_i && (port_o == dbus_pkg::port_uart);

    // bit 2 picks the rx register
    assign uart_rx_o   = dbus_cmd_i.addr[periph_pkg::uart_rx_bit];
    assign uart_byte_o = dbus_cmd_i.wdata[7:0];                   // tx byte only

endmodule

`default_nettype wire

// ==== dbus_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbus_mmu (
    input  wire logic                        w_clk,
    input  wire logic                        rst_n_i,
    input  wire dbus_pkg::dbus_cmd_t         dbus_cmd_i,
    input  wire logic                        dbus_cmd_valid_i,
    input  wire logic                        uart_wready_i,
    input  wire logic                        uart_rvalid_i,
    input  wire logic [7:0]                  uart_rdata_i,
    output logic                             dbus_ack_o,
    output logic [dbus_pkg::data_w-1:0]      dbus_rdata_o,
    output logic                             uart_wvalid_o,
    output logic [7:0]                       uart_wdata_o,
    output logic                             uart_rready_o
);

    periph_pkg::sdram_req_t      sdram_req;
    logic                        sdram_valid;
    logic                        sdram_ack;
    logic [dbus_pkg::data_w-1:0] sdram_rdata;
    logic                        uart_valid;
    logic                        uart_rx;
    logic [7:0]                  uart_byte;
    logic                        uart_ack;
    logic [dbus_pkg::data_w-1:0] uart_rdata;
    dbus_pkg::port_e             port;

    // ----------------------------------------------------------------------
    // decode
    // ----------------------------------------------------------------------
    dbus_decode i_dbus_decode (
        .dbus_cmd_i    (dbus_cmd_i),
        .cmd_valid_i   (dbus_cmd_valid_i),
        .sdram_req_o   (sdram_req),
        .sdram_valid_o (sdram_valid),
        .uart_valid_o  (uart_valid),
        .uart_rx_o     (uart_rx),
        .uart_byte_o   (uart_byte),
        .port_o        (port)
    );

    // ----------------------------------------------------------------------
    // targets
    // ----------------------------------------------------------------------
    sdram_ctrl i_sdram_ctrl (
        .w_clk   (w_clk),
        .rst_n_i (rst_n_i),
        .req_i   (sdram_req),
        .valid_i (sdram_valid),
        .ack_o   (sdram_ack),
        .rdata_o (sdram_rdata)
    );

    uart_port i_uart_port (
        .w_clk         (w_clk),
        .rst_n_i       (rst_n_i),
        .valid_i       (uart_valid),
        .rx_i          (uart_rx),
        .byte_i        (uart_byte),
        .uart_wready_i (uart_wready_i),
        .uart_rvalid_i (uart_rvalid_i),
        .uart_rdata_i  (uart_rdata_i),
        .uart_wvalid_o (uart_wvalid_o),
        .uart_wdata_o  (uart_wdata_o),
        .uart_rready_o (uart_rready_o),
        .ack_o         (uart_ack),
        .rdata_o       (uart_rdata)
    );

    // ----------------------------------------------------------------------
    // result
    // ----------------------------------------------------------------------
    dbus_result i_dbus_result (
        .w_clk         (w_clk),
        .rst_n_i       (rst_n_i),
        .cmd_valid_i   (dbus_cmd_valid_i),
        .port_i        (port),
        .sdram_ack_i   (sdram_ack),
        .sdram_rdata_i (sdram_rdata),
        .uart_ack_i    (uart_ack),
        .uart_rdata_i  (uart_rdata),
        .dbus_ack_o    (dbus_ack_o),
        .dbus_rdata_o  (dbus_rdata_o)
    );

endmodule

`default_nettype wire

// ==== dbus_pkg.sv ====
`default_nettype none

package dbus_pkg;

    // ----------------------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------------------
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;                      // one enable per byte lane

    // ----------------------------------------------------------------------
    // address map
    // ----------------------------------------------------------------------
    localparam int region_lsb = 28;
    localparam int region_w   = 4;                  // top nibble picks target

    localparam logic [region_w-1:0] region_sdram = 4'h0;
    localparam logic [region_w-1:0] region_uart  = 4'h1;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              we;                      // 1 = write
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] strb;
    } dbus_cmd_t;

    typedef enum logic [1:0] {
        port_sdram,
        port_uart,
        port_null                                   // unmapped regions
    } port_e;

endpackage

`default_nettype wire

// ==== dbus_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbus_result (
    input  wire logic                        w_clk,
    input  wire logic                        rst_n_i,
    input  wire logic                        cmd_valid_i,
    input  wire dbus_pkg::port_e             port_i,
    input  wire logic                        sdram_ack_i,
    input  wire logic [dbus_pkg::data_w-1:0] sdram_rdata_i,
    input  wire logic                        uart_ack_i,
    input  wire logic [dbus_pkg::data_w-1:0] uart_rdata_i,
    output logic                             dbus_ack_o,
    output logic [dbus_pkg::data_w-1:0]      dbus_rdata_o
);

    dbus_pkg::port_e port_q;                        // target of the command in flight
    logic            null_ack_q;
    logic            outstanding_q;

    always_ff @(posedge w_clk) begin
        if (!rst_n_i) begin
            port_q        <= dbus_pkg::port_null;
            null_ack_q    <= 1'b0;
            outstanding_q <= 1'b0;
        end else begin
            if (cmd_valid_i) port_q <= port_i;
            null_ack_q <= cmd_valid_i && (port_i == dbus_pkg::port_null);  // T+1 ack
            if (cmd_valid_i) begin
                outstanding_q <= 1'b1;
            end else if (dbus_ack_o) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (port_q)
            dbus_pkg::port_sdram: begin
                dbus_ack_o   = sdram_ack_i;
                dbus_rdata_o = sdram_rdata_i;
            end
            dbus_pkg::port_uart: begin
                dbus_ack_o   = uart_ack_i;
                dbus_rdata_o = uart_rdata_i;
            end
            default: begin
                dbus_ack_o   = null_ack_q;
                dbus_rdata_o = '0;                  // null target reads as zero
            end
        endcase
    end

    a_one_in_flight: assert property (
        @(posedge w_clk) disable iff (!rst_n_i) cmd_valid_i |-> !outstanding_q
    );

    a_ack_pulse: assert property (
        @(posedge w_clk) disable iff (!rst_n_i) dbus_ack_o |=> !dbus_ack_o
    );

endmodule

`default_nettype wire

// ==== periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    localparam int sdram_words = 1024;
    localparam int sdram_aw    = 10;                // word address bits

    // address bit that turns a uart access into a receive
    localparam int uart_rx_bit = 2;

    typedef struct packed {
        logic [sdram_aw-1:0]          addr;         // word address
        logic                         we;
        logic [dbus_pkg::data_w-1:0]  wdata;
        logic [dbus_pkg::strb_w-1:0]  strb;
    } sdram_req_t;

    typedef enum logic [1:0] {
        sdram_idle,
        sdram_write,
        sdram_read,
        sdram_ack
    } sdram_state_e;

    typedef enum logic [1:0] {
        uart_idle,
        uart_tx,
        uart_rx,
        uart_ack
    } uart_state_e;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the dbus_mmu testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

top=tb_dbus_mmu
obj=obj_dir

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f src.f --top-module "$top" -Mdir "$obj"; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$("./$obj/V$top" 2>&1); then
    printf '%s\n' "$output"
    echo "simulation exited with an error status"
    exit 1
fi

printf '%s\n' "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== sdram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl (
    input  wire logic                       w_clk,
    input  wire logic                       rst_n_i,
    input  wire periph_pkg::sdram_req_t     req_i,
    input  wire logic                       valid_i,
    output logic                            ack_o,
    output logic [dbus_pkg::data_w-1:0]     rdata_o
);

    periph_pkg::sdram_state_e    state_q;
    periph_pkg::sdram_req_t      req_q;                // request held for the sequencer
    logic [dbus_pkg::data_w-1:0] rdata_q;
    logic [dbus_pkg::data_w-1:0] mem_q [periph_pkg::sdram_words];

    // ----------------------------------------------------------------------
    // command sequencer
    // ----------------------------------------------------------------------
    always_ff @(posedge w_clk) begin
        if (!rst_n_i) begin
            state_q <= periph_pkg::sdram_idle;
        end else begin
            case (state_q)
                periph_pkg::sdram_idle: begin
                    if (valid_i) begin
                        if (req_i.we) begin
                            state_q <= periph_pkg::sdram_write;
                        end else begin
                            state_q <= periph_pkg::sdram_read;
                        end
                    end
                end
                periph_pkg::sdram_write: state_q <= periph_pkg::sdram_ack;
                periph_pkg::sdram_read:  state_q <= periph_pkg::sdram_ack;
                default:                 state_q <= periph_pkg::sdram_idle;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // storage and read path
    // ----------------------------------------------------------------------
    always_ff @(posedge w_clk) begin
        if (state_q == periph_pkg::sdram_idle && valid_i) begin
            req_q <= req_i;
        end

        if (state_q == periph_pkg::sdram_write) begin
            for (int i = 0; i < dbus_pkg::strb_w; i++) begin
                if (req_q.strb[i]) begin
                    mem_q[req_q.addr][8*i +: 8] <= req_q.wdata[8*i +: 8];  // lane i only
                end
            end
        end

        if (state_q == periph_pkg::sdram_read) begin
            rdata_q <= mem_q[req_q.addr];
        end
    end

    assign ack_o   = (state_q == periph_pkg::sdram_ack);   // T+2 after the command
    assign rdata_o = rdata_q;

    // the bus issues one command at a time, so a request never meets a busy sequencer
    a_valid_in_idle: assert property (
        @(posedge w_clk) disable iff (!rst_n_i)
        valid_i |-> state_q == periph_pkg::sdram_idle
    );

endmodule

`default_nettype wire

// ==== src.f ====
dbus_pkg.sv
periph_pkg.sv
dbus_decode.sv
sdram_ctrl.sv
uart_port.sv
dbus_result.sv
dbus_mmu.sv
tb_dbus_mmu.sv

// ==== tb_dbus_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dbus_mmu;

    localparam int reset_cycles = 8;
    localparam int n_words      = 16;               // scratch words under test
    localparam int n_rand       = 40;               // write then read pairs
    localparam int n_uart       = 12;               // per direction
    localparam int n_null       = 8;
    localparam int n_total      = 2 * n_words + 2 * n_rand + 2 * n_uart + n_null;
    localparam int cycle_limit  = 40 * n_total + reset_cycles;

    logic                 w_clk = 1'b0;
    logic                 rst_n_i;
    dbus_pkg::dbus_cmd_t  dbus_cmd_i;
    logic                 dbus_cmd_valid_i;
    logic                 uart_wready_i;
    logic                 uart_rvalid_i;
    logic [7:0]           uart_rdata_i;
    logic                 dbus_ack_o;
    logic [31:0]          dbus_rdata_o;
    logic                 uart_wvalid_o;
    logic [7:0]           uart_wdata_o;
    logic                 uart_rready_o;

    logic [15:0] lfsr_q = 16'd5046;
    logic [31:0] model [periph_pkg::sdram_words];   // byte-lane view of the RAM
    logic [9:0]  words [n_words];
    logic        cmd_pending;
    logic        uart_pending;
    int          errors  = 0;
    int          n_cmds  = 0;
    int          cycle_q = 0;

    always #20 w_clk = ~w_clk;

    dbus_mmu i_dbus_mmu (
        .w_clk            (w_clk),
        .rst_n_i          (rst_n_i),
        .dbus_cmd_i       (dbus_cmd_i),
        .dbus_cmd_valid_i (dbus_cmd_valid_i),
        .uart_wready_i    (uart_wready_i),
        .uart_rvalid_i    (uart_rvalid_i),
        .uart_rdata_i     (uart_rdata_i),
        .dbus_ack_o       (dbus_ack_o),
        .dbus_rdata_o     (dbus_rdata_o),
        .uart_wvalid_o    (uart_wvalid_o),
        .uart_wdata_o     (uart_wdata_o),
        .uart_rready_o    (uart_rready_o)
    );

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic report_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) v = {v[30:0], lfsr_step()};   // one step per bit
        return v;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  strb);
        logic [31:0] r;
        r = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) r[8*i +: 8] = new_w[8*i +: 8];
        end
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // bus driver
    // ----------------------------------------------------------------------
    task automatic send_cmd(input logic [31:0] addr, input logic we,
                            input logic [31:0] wdata, input logic [3:0] strb);
        @(posedge w_clk);
        dbus_cmd_i.addr  <= addr;
        dbus_cmd_i.we    <= we;
        dbus_cmd_i.wdata <= wdata;
        dbus_cmd_i.strb  <= strb;
        dbus_cmd_valid_i <= 1'b1;
        @(posedge w_clk);                           // DUT samples the command here
        dbus_cmd_valid_i <= 1'b0;
        dbus_cmd_i       <= ~{addr, we, wdata, strb};   // fields mean nothing after the strobe
        n_cmds++;
    endtask

    task automatic wait_ack(output int lat, output logic [31:0] rdata);
        lat = 0;
        do begin
            @(posedge w_clk);
            lat++;
        end while (!dbus_ack_o);                    // hang caught by cycle counter
        rdata = dbus_rdata_o;
    endtask

    task automatic ram_write(input logic [9:0] word, input logic [31:0] data,
                             input logic [3:0] strb);
        int          lat;
        logic [31:0] rdata;
        send_cmd({dbus_pkg::region_sdram, 16'h0, word, 2'b00}, 1'b1, data, strb);
        wait_ack(lat, rdata);
        assert (lat == 2) else report_mismatch($sformatf("ram write ack after %0d", lat));
        model[word] = merge_lanes(model[word], data, strb);
    endtask

    task automatic ram_read(input logic [9:0] word);
        int          lat;
        logic [31:0] rdata;
        send_cmd({dbus_pkg::region_sdram, 16'h0, word, 2'b00}, 1'b0, 32'h0, 4'h0);
        wait_ack(lat, rdata);
        assert (lat == 2) else report_mismatch($sformatf("ram read ack after %0d", lat));
        assert (rdata === model[word])
            else report_mismatch($sformatf("word %0d read %h, model %h",
                                           word, rdata, model[word]));
    endtask

    task automatic uart_cmd(input logic rx, input logic [31:0] wdata,
                            input logic [7:0] rx_byte, input int delay);
        int          lat;
        logic [31:0] rdata;
        logic [31:0] expected;
        send_cmd({dbus_pkg::region_uart, 25'h0, rx, 2'b00}, !rx, wdata, 4'hf);
        @(posedge w_clk);                           // first cycle after the command
        if (rx) begin
            assert (uart_rready_o) else report_mismatch("rready did not rise at T+1");
        end else begin
            assert (uart_wvalid_o && uart_wdata_o === wdata[7:0])
                else report_mismatch("wvalid or wdata wrong at T+1");
        end
        repeat (delay) @(posedge w_clk);            // partner stalls while the hold is checked
        if (rx) begin
            uart_rvalid_i <= 1'b1;
            uart_rdata_i  <= rx_byte;
        end else begin
            uart_wready_i <= 1'b1;
        end
        @(posedge w_clk);                           // handshake sampled
        uart_rvalid_i <= 1'b0;
        uart_wready_i <= 1'b0;
        wait_ack(lat, rdata);
        expected = rx ? {24'h0, rx_byte} : 32'h0;
        assert (lat == 1) else report_mismatch($sformatf("uart ack after %0d", lat));
        assert (rdata === expected)
            else report_mismatch($sformatf("uart read %h, expected %h", rdata, expected));
    endtask

    task automatic null_cmd(input logic [3:0] region, input logic [9:0] word,
                            input logic we, input logic [31:0] data);
        int          lat;
        logic [31:0] rdata;
        send_cmd({region, 16'h0, word, 2'b00}, we, data, 4'hf);
        wait_ack(lat, rdata);
        assert (lat == 1) else report_mismatch($sformatf("null ack after %0d", lat));
        assert (rdata === 32'h0) else report_mismatch($sformatf("null read %h", rdata));
    endtask

    // ----------------------------------------------------------------------
    // protocol watchers
    // ----------------------------------------------------------------------
    always @(posedge w_clk) begin
        cycle_q <= cycle_q + 1;
        if (!rst_n_i) begin
            cmd_pending  <= 1'b0;
            uart_pending <= 1'b0;
        end else if (dbus_cmd_valid_i) begin
            cmd_pending  <= 1'b1;
            uart_pending <= dbus_cmd_i.addr[31:28] == dbus_pkg::region_uart;
        end else if (dbus_ack_o) begin
            cmd_pending  <= 1'b0;
            uart_pending <= 1'b0;
        end
        if (cycle_q >= cycle_limit) begin
            $display("timeout: run passed %0d cycles without finishing", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    a_ack_single: assert property (
        @(posedge w_clk) disable iff (!rst_n_i) dbus_ack_o |=> !dbus_ack_o
    ) else report_mismatch("ack longer than one cycle");

    a_ack_owed: assert property (
        @(posedge w_clk) disable iff (!rst_n_i) dbus_ack_o |-> cmd_pending
    ) else report_mismatch("ack without a command in flight");

    a_strobe_owed: assert property (
        @(posedge w_clk) disable iff (!rst_n_i)
        (uart_wvalid_o || uart_rready_o) |-> uart_pending
    ) else report_mismatch("uart strobe without a uart command");

    a_wvalid_hold: assert property (
        @(posedge w_clk) disable iff (!rst_n_i)
        uart_wvalid_o && !uart_wready_i |=> uart_wvalid_o && $stable(uart_wdata_o)
    ) else report_mismatch("wvalid or wdata dropped before wready");

    a_rready_hold: assert property (
        @(posedge w_clk) disable iff (!rst_n_i)
        uart_rready_o && !uart_rvalid_i |=> uart_rready_o
    ) else report_mismatch("rready dropped before rvalid");

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        int          k;
        int          delay;
        logic [3:0]  region;
        logic [31:0] data;
        logic [7:0]  rx_byte;
        rst_n_i          <= 1'b0;
        dbus_cmd_i       <= '0;
        dbus_cmd_valid_i <= 1'b0;
        uart_wready_i    <= 1'b0;
        uart_rvalid_i    <= 1'b0;
        uart_rdata_i     <= 8'h0;
        repeat (reset_cycles) @(posedge w_clk);
        rst_n_i <= 1'b1;
        repeat (4) begin
            @(posedge w_clk);
            assert (!dbus_ack_o && !uart_wvalid_o && !uart_rready_o)
                else report_mismatch("output active while idle after reset");
        end
        for (int i = 0; i < n_words; i++) begin     // full words first so no lane stays X
            words[i] = 10'(draw(10));
            ram_write(words[i], draw(32), 4'hf);
        end
        for (int i = 0; i < n_rand; i++) begin
            k    = int'(draw(4));
            data = draw(32);
            ram_write(words[k], data, 4'(draw(4)));
            ram_read(words[k]);
        end
        for (int i = 0; i < n_uart; i++) begin
            data    = draw(32);
            rx_byte = 8'(draw(8));
            delay   = int'(draw(3));
            uart_cmd(1'b0, data, rx_byte, delay);
            data    = draw(32);
            rx_byte = 8'(draw(8));
            delay   = int'(draw(3));
            uart_cmd(1'b1, data, rx_byte, delay);
        end
        for (int i = 0; i < n_null; i++) begin
            region = 4'(draw(4));
            if (region < 4'd2) region = region + 4'd2;   // skip ram and uart
            data = draw(32);
            null_cmd(region, words[i], 1'(draw(1)), data);
        end
        for (int i = 0; i < n_words; i++) ram_read(words[i]);  // null writes left no trace
        repeat (4) @(posedge w_clk);
        $display("summary: %0d commands, %0d errors", n_cmds, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_port (
    input  wire logic                    w_clk,
    input  wire logic                    rst_n_i,
    input  wire logic                    valid_i,
    input  wire logic                    rx_i,
    input  wire logic [7:0]              byte_i,
    input  wire logic                    uart_wready_i,
    input  wire logic                    uart_rvalid_i,
    input  wire logic [7:0]              uart_rdata_i,
    output logic                         uart_wvalid_o,
    output logic [7:0]                   uart_wdata_o,
    output logic                         uart_rready_o,
    output logic                         ack_o,
    output logic [dbus_pkg::data_w-1:0]  rdata_o
);

    periph_pkg::uart_state_e state_q;
    logic [7:0]              tx_byte_q;
    logic [7:0]              rx_byte_q;

    always_ff @(posedge w_clk) begin
        if (!rst_n_i) begin
            state_q <= periph_pkg::uart_idle;
        end else begin
            case (state_q)
                periph_pkg::uart_idle: begin
                    if (valid_i && rx_i) begin
                        state_q <= periph_pkg::uart_rx;
                    end else if (valid_i) begin
                        state_q <= periph_pkg::uart_tx;
                    end
                end
                periph_pkg::uart_tx: if (uart_wready_i) state_q <= periph_pkg::uart_ack;
                periph_pkg::uart_rx: if (uart_rvalid_i) state_q <= periph_pkg::uart_ack;
                default:             state_q <= periph_pkg::uart_idle;
            endcase
        end
    end

    always_ff @(posedge w_clk) begin
        if (state_q == periph_pkg::uart_idle && valid_i) begin
            tx_byte_q <= byte_i;
            if (!rx_i) rx_byte_q <= '0;                    // tx acks with zero data
        end
        if (state_q == periph_pkg::uart_rx && uart_rvalid_i) begin
            rx_byte_q <= uart_rdata_i;
        end
    end

    assign uart_wvalid_o = (state_q == periph_pkg::uart_tx);
    assign uart_rready_o = (state_q == periph_pkg::uart_rx);
    assign uart_wdata_o  = tx_byte_q;
    assign ack_o         = (state_q == periph_pkg::uart_ack);
    assign rdata_o       = {{(dbus_pkg::data_w-8){1'b0}}, rx_byte_q};  // zero-extended

    a_one_direction: assert property (
        @(posedge w_clk) disable iff (!rst_n_i) !(uart_wvalid_o && uart_rready_o)
    );

    // external uart may stall, the byte must wait for it
    a_wvalid_hold: assert property (
        @(posedge w_clk) disable iff (!rst_n_i)
        uart_wvalid_o && !uart_wready_i |=> uart_wvalid_o
    );

endmodule

`default_nettype wire
